//--- verilog/exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Operand, result and shifter width
`define EXEC_DATA_WIDTH 32

// Request FIFO entries, also the sender's starting credits
`define EXEC_QUEUE_DEPTH 4

// Results the consumer can hold at once, starting output credits
`define EXEC_OUT_CREDITS 2

`endif

//--- verilog/armIsaPkg.sv
`default_nettype none

package armIsaPkg;

  // Data-processing opcode, instruction bits 24:21
  typedef enum logic [3:0] {
    AND = 4'b0000,
    EOR = 4'b0001,
    SUB = 4'b0010,
    RSB = 4'b0011,
    ADD = 4'b0100,
    ADC = 4'b0101,
    SBC = 4'b0110,
    RSC = 4'b0111,
    TST = 4'b1000,
    TEQ = 4'b1001,
    CMP = 4'b1010,
    CMN = 4'b1011,
    ORR = 4'b1100,
    MOV = 4'b1101,
    BIC = 4'b1110,
    MVN = 4'b1111
  } dpOpcode;

  // Result source selected inside the ALU
  typedef enum logic [2:0] {
    OP_AND   = 3'b000,
    OP_XOR   = 3'b001,
    OP_SUM   = 3'b010,
    OP_OR    = 3'b011,
    OP_PASSB = 3'b100
  } aluOperation;

  // How C and V are produced
  typedef enum logic [2:0] {
    CV_LOGIC     = 3'b000, // C from shifter, V held
    CV_ADD       = 3'b100, // Adder carry, add overflow
    CV_SUB       = 3'b101, // Adder carry, subtract overflow
    CV_ADD_KEEPV = 3'b110  // As add, V held on keepV hint
  } cvUpdate;

  typedef enum logic [1:0] {
    LSL = 2'b00,
    LSR = 2'b01,
    ASR = 2'b10,
    ROR = 2'b11
  } shiftType;

endpackage

`default_nettype wire

//--- verilog/execStagePkg.sv
`default_nettype none

`include "exec_macros.svh"

package execStagePkg;

  // One instruction as handed to the execute stage
  typedef struct packed {
    logic                        aluOp;       // Low for the address add
    armIsaPkg::dpOpcode          opcode;
    logic                        setFlags;    // S bit
    logic                        keepV;       // Hold V on ADD
    logic [`EXEC_DATA_WIDTH-1:0] operandA;
    logic [`EXEC_DATA_WIDTH-1:0] operandB;    // Pre-shift value
    armIsaPkg::shiftType         shift;
    logic [4:0]                  shiftAmount; // Immediate amount only
    logic [3:0]                  destReg;
  } execRequest;

  // Decoder outputs steering the ALU
  typedef struct packed {
    armIsaPkg::aluOperation operation;
    armIsaPkg::cvUpdate     cvMode;
    logic                   invertB;       // Ones complement of B after swap
    logic                   reverseInputs; // RSB, RSC
    logic                   carryIn;
    logic                   noWrite;       // Compares skip the register file
  } aluControl;

  typedef struct packed {
    logic [`EXEC_DATA_WIDTH-1:0] value;
    logic [3:0]                  destReg;
    logic                        writeReg;
    logic [3:0]                  flags; // NZCV after this instruction
  } execResult;

endpackage

`default_nettype wire

//--- verilog/aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
  input  logic                   aluOp,
  input  armIsaPkg::dpOpcode     opcode,
  input  logic                   previousCarry,
  output execStagePkg::aluControl control
);

  logic isCompare; // TST, TEQ, CMP, CMN
  logic isReverse;
  logic isInvert;

  assign isCompare = opcode inside {armIsaPkg::TST, armIsaPkg::TEQ,
                                    armIsaPkg::CMP, armIsaPkg::CMN};
  assign isReverse = opcode inside {armIsaPkg::RSB, armIsaPkg::RSC};
  assign isInvert  = opcode inside {armIsaPkg::SUB, armIsaPkg::RSB, armIsaPkg::SBC,
                                    armIsaPkg::RSC, armIsaPkg::CMP, armIsaPkg::MVN,
                                    armIsaPkg::BIC};

  always_comb begin
    // Address add unless a data-processing op overrides
    control.operation     = armIsaPkg::OP_SUM;
    control.cvMode        = armIsaPkg::CV_ADD;
    control.carryIn       = 1'b0;
    control.reverseInputs = aluOp & isReverse;
    control.invertB       = aluOp & isInvert;
    control.noWrite       = aluOp & isCompare;
    if (aluOp) begin
      case (opcode)
        armIsaPkg::AND, armIsaPkg::TST, armIsaPkg::BIC: begin // BIC via inverted B
          control.operation = armIsaPkg::OP_AND;
          control.cvMode    = armIsaPkg::CV_LOGIC;
        end
        armIsaPkg::EOR, armIsaPkg::TEQ: begin
          control.operation = armIsaPkg::OP_XOR;
          control.cvMode    = armIsaPkg::CV_LOGIC;
        end
        armIsaPkg::ORR: begin
          control.operation = armIsaPkg::OP_OR;
          control.cvMode    = armIsaPkg::CV_LOGIC;
        end
        armIsaPkg::MOV, armIsaPkg::MVN: begin // B only, MVN inverted
          control.operation = armIsaPkg::OP_PASSB;
          control.cvMode    = armIsaPkg::CV_LOGIC;
        end
        armIsaPkg::SUB, armIsaPkg::RSB, armIsaPkg::CMP: begin
          control.cvMode  = armIsaPkg::CV_SUB;
          control.carryIn = 1'b1; // Completes the twos complement
        end
        armIsaPkg::SBC, armIsaPkg::RSC: begin
          control.cvMode  = armIsaPkg::CV_SUB;
          control.carryIn = previousCarry; // Borrow is inverted C
        end
        armIsaPkg::ADC: begin
          control.carryIn = previousCarry;
        end
        armIsaPkg::ADD: begin
          control.cvMode = armIsaPkg::CV_ADD_KEEPV; // Only ADD honours keepV
        end
        default: begin // CMN, plain add
          control.cvMode = armIsaPkg::CV_ADD;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/barrelShifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module barrelShifter (
  input  logic [`EXEC_DATA_WIDTH-1:0] value,
  input  armIsaPkg::shiftType         shift,
  input  logic [4:0]                  amount,
  input  logic                        carryInFlag, // Current C
  output logic [`EXEC_DATA_WIDTH-1:0] shifted,
  output logic                        carryOut
);

  localparam int Width = `EXEC_DATA_WIDTH;

  logic        [Width:0]     leftWide;   // Top bit catches the last bit out
  logic        [Width:0]     rightWide;  // Bottom bit catches the last bit out
  logic signed [Width:0]     arithWide;
  logic        [2*Width-1:0] rotateWide; // Doubled copy for rotation

  assign leftWide   = {1'b0, value} << amount;
  assign rightWide  = {value, 1'b0} >> amount;
  assign arithWide  = $signed({value, 1'b0}) >>> amount; // Sign fills from the left
  assign rotateWide = {value, value} >> amount;

  always_comb begin
    if (amount == 5'd0) begin
      shifted  = value; // No shift, C unchanged
      carryOut = carryInFlag;
    end else begin
      case (shift)
        armIsaPkg::LSL: begin
          shifted  = leftWide[Width-1:0];
          carryOut = leftWide[Width];
        end
        armIsaPkg::LSR: begin
          shifted  = rightWide[Width:1];
          carryOut = rightWide[0];
        end
        armIsaPkg::ASR: begin
          shifted  = arithWide[Width:1];
          carryOut = arithWide[0];
        end
        default: begin // ROR, C is the new MSB
          shifted  = rotateWide[Width-1:0];
          carryOut = rotateWide[Width-1];
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module alu (
  input  execStagePkg::aluControl     control,
  input  logic [`EXEC_DATA_WIDTH-1:0] operandA,
  input  logic [`EXEC_DATA_WIDTH-1:0] operandB,     // Already shifted
  input  logic                        shifterCarry,
  input  logic                        keepV,
  input  logic [3:0]                  previousFlags, // NZCV
  output logic [`EXEC_DATA_WIDTH-1:0] result,
  output logic [3:0]                  flags          // NZCV
);

  localparam int Width = `EXEC_DATA_WIDTH;

  logic [Width-1:0] srcA;
  logic [Width-1:0] srcB;
  logic [Width-1:0] condB;  // srcB after optional inversion
  logic [Width:0]   sum;    // Carry out in the top bit
  logic             addOverflow;
  logic             subOverflow;
  logic             carry;
  logic             overflow;
  logic             previousV;

  assign previousV = previousFlags[0];

  // Swap for reverse subtracts
  assign srcA  = control.reverseInputs ? operandB : operandA;
  assign srcB  = control.reverseInputs ? operandA : operandB;
  assign condB = control.invertB ? ~srcB : srcB;

  assign sum = {1'b0, srcA} + {1'b0, condB} + {{Width{1'b0}}, control.carryIn};

  // Same-sign inputs, result sign flipped
  assign addOverflow = ~(srcA[Width-1] ^ srcB[Width-1]) & (srcA[Width-1] ^ sum[Width-1]);
  // Different-sign inputs, result sign differs from minuend
  assign subOverflow = (srcA[Width-1] ^ srcB[Width-1]) & (srcA[Width-1] ^ sum[Width-1]);

  always_comb begin
    case (control.operation)
      armIsaPkg::OP_AND:   result = srcA & condB; // BIC gets inverted B
      armIsaPkg::OP_XOR:   result = srcA ^ condB;
      armIsaPkg::OP_OR:    result = srcA | condB;
      armIsaPkg::OP_PASSB: result = condB;        // MOV, MVN
      default:             result = sum[Width-1:0];
    endcase
  end

  always_comb begin
    case (control.cvMode)
      armIsaPkg::CV_ADD: begin
        carry    = sum[Width];
        overflow = addOverflow;
      end
      armIsaPkg::CV_ADD_KEEPV: begin
        carry    = sum[Width];
        overflow = keepV ? previousV : addOverflow;
      end
      armIsaPkg::CV_SUB: begin
        carry    = sum[Width]; // Set means no borrow
        overflow = subOverflow;
      end
      default: begin // Logic ops
        carry    = shifterCarry;
        overflow = previousV;
      end
    endcase
  end

  // N and Z straight off the result
  assign flags = {result[Width-1], result == '0, carry, overflow};

endmodule

`default_nettype wire

//--- verilog/requestQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module requestQueue (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     push,
  input  execStagePkg::execRequest pushData,
  input  logic                     pop,
  output execStagePkg::execRequest head,
  output logic                     notEmpty,
  output logic                     creditReturn // One per popped entry
);

  localparam int Depth      = `EXEC_QUEUE_DEPTH;
  localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountWidth = $clog2(Depth + 1);

  execStagePkg::execRequest entries [Depth];
  logic [PtrWidth-1:0]      readPtr;
  logic [PtrWidth-1:0]      writePtr;
  logic [CountWidth-1:0]    occupancy;
  logic                     doPop;

  assign doPop    = pop & notEmpty; // Ignore pops on empty
  assign notEmpty = occupancy != '0;
  assign head     = entries[readPtr];

  always_ff @(posedge clk) begin
    if (reset) begin
      readPtr      <= '0;
      writePtr     <= '0;
      occupancy    <= '0;
      creditReturn <= 1'b0;
    end else begin
      creditReturn <= doPop; // Pulse the cycle after the pop
      if (push) begin
        writePtr <= (writePtr == PtrWidth'(Depth - 1)) ? '0 : writePtr + 1'b1;
      end
      if (doPop) begin
        readPtr <= (readPtr == PtrWidth'(Depth - 1)) ? '0 : readPtr + 1'b1;
      end
      case ({push, doPop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy; // Both or neither
      endcase
    end
  end

  // Storage, sender credits keep it from overflowing
  always_ff @(posedge clk) begin
    if (push) begin
      entries[writePtr] <= pushData;
    end
  end

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module executeStage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     inValid,
  input  execStagePkg::execRequest inRequest,
  output logic                     inCreditReturn,
  output logic                     outValid,
  output execStagePkg::execResult  outResult,
  input  logic                     outCreditReturn,
  output logic [3:0]               flags // Architectural NZCV
);

  localparam int CreditWidth = $clog2(`EXEC_OUT_CREDITS + 1);

  execStagePkg::execRequest    head;
  execStagePkg::aluControl     control;
  logic                        notEmpty;
  logic                        popNow;
  logic [CreditWidth-1:0]      outCredits;
  logic [`EXEC_DATA_WIDTH-1:0] shiftedB;
  logic                        shifterCarry;
  logic [`EXEC_DATA_WIDTH-1:0] aluResult;
  logic [3:0]                  aluFlags;
  logic                        flagWrite;
  logic [3:0]                  nextFlags;

  // Issue only with something queued and room downstream
  assign popNow = notEmpty & (outCredits != '0);

  requestQueue queue (
    .clk          (clk),
    .reset        (reset),
    .push         (inValid),
    .pushData     (inRequest),
    .pop          (popNow),
    .head         (head),
    .notEmpty     (notEmpty),
    .creditReturn (inCreditReturn)
  );

  aluDecoder decoder (
    .aluOp         (head.aluOp),
    .opcode        (head.opcode),
    .previousCarry (flags[1]),
    .control       (control)
  );

  barrelShifter shifter (
    .value       (head.operandB),
    .shift       (head.shift),
    .amount      (head.shiftAmount),
    .carryInFlag (flags[1]),
    .shifted     (shiftedB),
    .carryOut    (shifterCarry)
  );

  alu datapath (
    .control       (control),
    .operandA      (head.operandA),
    .operandB      (shiftedB),
    .shifterCarry  (shifterCarry),
    .keepV         (head.keepV),
    .previousFlags (flags),
    .result        (aluResult),
    .flags         (aluFlags)
  );

  // Compares always write flags, noWrite marks exactly those
  assign flagWrite = head.setFlags | control.noWrite;
  assign nextFlags = flagWrite ? aluFlags : flags;

  always_ff @(posedge clk) begin
    if (reset) begin
      flags      <= 4'b0000;
      outValid   <= 1'b0;
      outCredits <= CreditWidth'(`EXEC_OUT_CREDITS);
    end else begin
      outValid <= popNow; // Single-cycle completion strobe
      if (popNow) begin
        flags <= nextFlags;
      end
      case ({popNow, outCreditReturn})
        2'b10:   outCredits <= outCredits - 1'b1;
        2'b01:   outCredits <= outCredits + 1'b1;
        default: outCredits <= outCredits; // Spend and refund cancel
      endcase
    end
  end

  // Result payload, qualified by outValid
  always_ff @(posedge clk) begin
    if (popNow) begin
      outResult.value    <= aluResult;
      outResult.destReg  <= head.destReg;
      outResult.writeReg <= ~control.noWrite;
      outResult.flags    <= nextFlags;
    end
  end

endmodule

`default_nettype wire

//--- testbench/executeStage_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module executeStage_checker #(
  parameter int CreditWidth = $clog2(`EXEC_OUT_CREDITS + 1)
) (
  input logic                   clk,
  input logic                   reset,
  input logic                   inValid,    // Push into the request FIFO
  input logic                   popNow,     // Issue from the FIFO head
  input logic                   outValid,
  input logic                   outCreditReturn,
  input logic [CreditWidth-1:0] outCredits
);

  localparam int CountWidth = $clog2(`EXEC_QUEUE_DEPTH + 2); // Headroom to see overflow
  localparam int HeldWidth  = $clog2(`EXEC_OUT_CREDITS + 2);

  logic [CountWidth-1:0] occupancy;   // Shadow of the FIFO fill level
  logic [HeldWidth-1:0]  outstanding; // Results the consumer still holds

  always_ff @(posedge clk) begin
    if (reset) begin
      occupancy <= '0;
    end else begin
      occupancy <= occupancy + CountWidth'(inValid) - CountWidth'(popNow);
    end
  end

  // Counted from the output pins only
  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + HeldWidth'(outValid) - HeldWidth'(outCreditReturn);
    end
  end

  creditSpent: assert property (@(posedge clk) disable iff (reset)
    outstanding <= HeldWidth'(`EXEC_OUT_CREDITS))
    else $error("Result issued while no output credit was left");

  creditCeiling: assert property (@(posedge clk) disable iff (reset)
    outCredits <= CreditWidth'(`EXEC_OUT_CREDITS))
    else $error("Output credit count above its starting value");

  queueBound: assert property (@(posedge clk) disable iff (reset)
    occupancy <= CountWidth'(`EXEC_QUEUE_DEPTH))
    else $error("Request FIFO holds more entries than its depth");

  quietInReset: assert property (@(posedge clk) reset |=> !outValid)
    else $error("outValid high right after a reset cycle");

endmodule

`default_nettype wire

//--- testbench/executeStage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module executeStage_tb;

  localparam int NumRows    = 27;
  localparam int HoldCycles = 40;   // Output credits withheld this long
  localparam int WaitLimit  = 1000; // Cycles before any wait gives up
  localparam armIsaPkg::shiftType Lsl = armIsaPkg::LSL;
  localparam armIsaPkg::shiftType Lsr = armIsaPkg::LSR;
  localparam armIsaPkg::shiftType Asr = armIsaPkg::ASR;
  localparam armIsaPkg::shiftType Ror = armIsaPkg::ROR;

  logic                     clk;
  logic                     reset;
  logic                     inValid;
  execStagePkg::execRequest inRequest;
  logic                     inCreditReturn;
  logic                     outValid;
  execStagePkg::execResult  outResult;
  logic                     outCreditReturn = 1'b0;
  logic [3:0]               dutFlags;

  // Stimulus table, one request and its expected result per row
  string                    rowName    [NumRows];
  execStagePkg::execRequest rowRequest [NumRows];
  logic [31:0]              rowValue   [NumRows];
  logic                     rowWrite   [NumRows];
  logic [3:0]               rowFlags   [NumRows]; // NZCV, carried row to row
  int                       rowCount = 0;

  int          errorCount    = 0;
  int          checkCount    = 0;
  int          sentCount     = 0;
  int          creditsBack   = 0; // Input credits seen
  int          receivedCount = 0;
  int          returnedCount = 0; // Output credits handed back
  int          heldResults   = 0; // Results seen while credits are withheld
  logic        holdCredits   = 1'b0;
  logic [31:0] lcgState      = 32'h79cb_86eb;
  int          returnDelay   = 0;

  executeStage uut (
    .clk             (clk),
    .reset           (reset),
    .inValid         (inValid),
    .inRequest       (inRequest),
    .inCreditReturn  (inCreditReturn),
    .outValid        (outValid),
    .outResult       (outResult),
    .outCreditReturn (outCreditReturn),
    .flags           (dutFlags)
  );

  bind executeStage executeStage_checker rules (
    .clk             (clk),
    .reset           (reset),
    .inValid         (inValid),
    .popNow          (popNow),
    .outValid        (outValid),
    .outCreditReturn (outCreditReturn),
    .outCredits      (outCredits)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic abortRun(input string what);
    errorCount++;
    $display("Timed out waiting for %s", what);
    $display("Checks: %0d  errors: %0d", checkCount, errorCount);
    $display("Testbench failed");
    $finish;
  endtask

  // ctl is {aluOp, setFlags, keepV}, destReg follows the row number
  task automatic addRow(input string name, input logic [2:0] ctl, input armIsaPkg::dpOpcode op,
                        input logic [31:0] a, input logic [31:0] b,
                        input armIsaPkg::shiftType sh, input int amt,
                        input logic [31:0] value, input logic write, input logic [3:0] nzcv);
    execStagePkg::execRequest req;
    req.aluOp       = ctl[2];
    req.opcode      = op;
    req.setFlags    = ctl[1];
    req.keepV       = ctl[0];
    req.operandA    = a;
    req.operandB    = b;
    req.shift       = sh;
    req.shiftAmount = amt[4:0];
    req.destReg     = rowCount[3:0];
    rowName[rowCount]    = name;
    rowRequest[rowCount] = req;
    rowValue[rowCount]   = value;
    rowWrite[rowCount]   = write;
    rowFlags[rowCount]   = nzcv;
    rowCount++;
  endtask

  task automatic buildTable();
    addRow("add", 3'b110, armIsaPkg::ADD, 'h5, 'h3, Lsl, 0, 'h8, 1, 4'b0000);
    addRow("add_v", 3'b110, armIsaPkg::ADD, 'h7fffffff, 'h1, Lsl, 0, 'h80000000, 1, 4'b1001);
    addRow("add_c", 3'b110, armIsaPkg::ADD, 'hffffffff, 'h1, Lsl, 0, 'h0, 1, 4'b0110);
    addRow("adc_chain", 3'b110, armIsaPkg::ADC, 'hffffffff, 'h0, Lsl, 0, 'h0, 1, 4'b0110);
    addRow("adc_cin", 3'b110, armIsaPkg::ADC, 'h10, 'h20, Lsl, 0, 'h31, 1, 4'b0000);
    addRow("sub", 3'b110, armIsaPkg::SUB, 'ha, 'h3, Lsl, 0, 'h7, 1, 4'b0010);
    addRow("sub_brw", 3'b110, armIsaPkg::SUB, 'h3, 'ha, Lsl, 0, 'hfffffff9, 1, 4'b1000);
    addRow("sbc_brw", 3'b110, armIsaPkg::SBC, 'h64, 'h1e, Lsl, 0, 'h45, 1, 4'b0010);
    addRow("sub_v", 3'b110, armIsaPkg::SUB, 'h80000000, 'h1, Lsl, 0, 'h7fffffff, 1, 4'b0011);
    addRow("rsb", 3'b110, armIsaPkg::RSB, 'h5, 'h14, Lsl, 0, 'hf, 1, 4'b0010);
    addRow("rsc", 3'b110, armIsaPkg::RSC, 'h7, 'h7, Lsl, 0, 'h0, 1, 4'b0110);
    addRow("and_lsl", 3'b110, armIsaPkg::AND, 'hffffff00, 'h81, Lsl, 4, 'h800, 1, 4'b0000);
    addRow("eor_lsr", 3'b110, armIsaPkg::EOR, 'hff, 'h3, Lsr, 1, 'hfe, 1, 4'b0010);
    addRow("orr_asr", 3'b110, armIsaPkg::ORR, 'h1, 'h80000000, Asr, 4, 'hf8000001, 1, 4'b1000);
    addRow("bic_ror", 3'b110, armIsaPkg::BIC, 'hffffffff, 'hf8, Ror, 4, 'h7ffffff0, 1, 4'b0010);
    addRow("mov_zero", 3'b110, armIsaPkg::MOV, 'h0, 'h12345678, Ror, 0, 'h12345678, 1, 4'b0010);
    addRow("mvn", 3'b110, armIsaPkg::MVN, 'h0, 'h0, Lsl, 0, 'hffffffff, 1, 4'b1010);
    addRow("tst", 3'b100, armIsaPkg::TST, 'hf0, 'hf, Lsl, 0, 'h0, 0, 4'b0110);
    addRow("teq", 3'b100, armIsaPkg::TEQ, 'h80000000, 'h0, Lsl, 0, 'h80000000, 0, 4'b1010);
    addRow("cmp_eq", 3'b100, armIsaPkg::CMP, 'h2a, 'h2a, Lsl, 0, 'h0, 0, 4'b0110);
    addRow("cmp_lt", 3'b100, armIsaPkg::CMP, 'h1, 'h2, Lsl, 0, 'hffffffff, 0, 4'b1000);
    addRow("cmn", 3'b100, armIsaPkg::CMN, 'h7fffffff, 'h1, Lsl, 0, 'h80000000, 0, 4'b1001);
    addRow("add_nos", 3'b100, armIsaPkg::ADD, 'h1, 'h1, Lsl, 0, 'h2, 1, 4'b1001);
    addRow("sub_nos", 3'b100, armIsaPkg::SUB, 'h0, 'h1, Lsl, 0, 'hffffffff, 1, 4'b1001);
    addRow("addr_add", 3'b000, armIsaPkg::CMP, 'h1000, 'h9, Lsl, 2, 'h1024, 1, 4'b1001);
    addRow("add_keepv", 3'b111, armIsaPkg::ADD, 'h1, 'h1, Lsl, 0, 'h2, 1, 4'b0001);
    addRow("add_clrv", 3'b110, armIsaPkg::ADD, 'h1, 'h1, Lsl, 0, 'h2, 1, 4'b0000);
  endtask

  // Back-to-back sends while an input credit is held
  task automatic sendTable();
    int waited;
    for (int i = 0; i < NumRows; i++) begin
      waited = 0;
      while (sentCount - creditsBack >= `EXEC_QUEUE_DEPTH) begin
        inValid = 1'b0;
        @(negedge clk);
        waited++;
        if (waited > WaitLimit) abortRun("an input credit");
      end
      inValid   = 1'b1;
      inRequest = rowRequest[i];
      sentCount++;
      @(negedge clk);
    end
    inValid = 1'b0;
  endtask

  task automatic waitDrained(input int target);
    int waited;
    waited = 0;
    while (receivedCount < target || returnedCount < target) begin
      @(negedge clk);
      waited++;
      if (waited > WaitLimit) abortRun("results and output credits to drain");
    end
  endtask

  // Scoreboard, results matched in request order
  always @(posedge clk) begin
    int idx;
    if (!reset && outValid) begin
      if (receivedCount >= 2 * NumRows) begin
        errorCount++;
        $display("Unexpected extra result for register %0d", outResult.destReg);
      end else begin
        idx = receivedCount % NumRows;
        compareValue({rowName[idx], " value"}, rowValue[idx], outResult.value);
        compareValue({rowName[idx], " destReg"}, 32'(rowRequest[idx].destReg),
                     32'(outResult.destReg));
        compareValue({rowName[idx], " writeReg"}, 32'(rowWrite[idx]), 32'(outResult.writeReg));
        compareValue({rowName[idx], " flags"}, 32'(rowFlags[idx]), 32'(outResult.flags));
      end
      receivedCount++;
      if (holdCredits) heldResults++;
    end
    if (!reset && inCreditReturn) begin
      creditsBack++;
      if (creditsBack > sentCount) begin
        errorCount++;
        $display("More input credits came back than requests were sent");
      end
    end
  end

  // Consumer hands credits back after a random 0 to 7 cycle delay
  always @(negedge clk) begin
    outCreditReturn = 1'b0;
    if (!reset && !holdCredits && returnedCount < receivedCount) begin
      if (returnDelay == 0) begin
        outCreditReturn = 1'b1;
        returnedCount++;
        lcgState    = lcgNext(lcgState);
        returnDelay = int'(lcgState[30:28]);
      end else begin
        returnDelay--;
      end
    end
  end

  initial begin
    reset     = 1'b1;
    inValid   = 1'b0;
    inRequest = '0;
    buildTable();
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    compareValue("reset outValid", 32'(1'b0), 32'(outValid));
    compareValue("reset inCreditReturn", 32'(1'b0), 32'(inCreditReturn));
    compareValue("reset flags", 32'(4'b0000), 32'(dutFlags));

    sendTable(); // Credits flowing
    waitDrained(NumRows);

    holdCredits = 1'b1; // Replay with the consumer stalled
    fork
      sendTable();
      begin
        repeat (HoldCycles) @(negedge clk);
        compareValue("held results", `EXEC_OUT_CREDITS, heldResults);
        holdCredits = 1'b0;
      end
    join
    waitDrained(2 * NumRows);

    compareValue("final flags", 32'(rowFlags[NumRows-1]), 32'(dutFlags));
    compareValue("input credits back", sentCount, creditsBack);
    $display("Checks: %0d  errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+verilog
verilog/armIsaPkg.sv
verilog/execStagePkg.sv
verilog/aluDecoder.sv
verilog/barrelShifter.sv
verilog/alu.sv
verilog/requestQueue.sv
verilog/executeStage.sv
testbench/executeStage_checker.sv
testbench/executeStage_tb.sv

//--- Makefile
LOG := sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module executeStage_tb -Mdir obj_dir -o Vtb
	./obj_dir/Vtb | tee $(LOG)
	@! grep -q "Testbench failed" $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
